/* logic/cdc_pkg.sv */
package cdc_pkg;

    // ==================================================
    // endpoints
    // ==================================================
    typedef logic [3:0] endpt_t;

    localparam endpt_t EP_CTRL = 4'd0;  // default control pipe
    localparam endpt_t EP_BULK = 4'd2;  // cdc data pipe, in and out

    // ==================================================
    // fifo and packet sizes
    // ==================================================
    localparam int FIFO_DEPTH = 128;     // bytes per fifo
    typedef logic [7:0] fifo_cnt_t;      // holds 0..FIFO_DEPTH

    localparam int MAX_PKT = 64;         // full speed bulk max
    typedef logic [11:0] pkt_len_t;      // length field toward the controller

    // ==================================================
    // class requests on ep0
    // ==================================================
    localparam logic [7:0] REQ_SET_LINE_CODING     = 8'h20;
    localparam logic [7:0] REQ_GET_LINE_CODING     = 8'h21;
    localparam logic [7:0] REQ_SET_CTRL_LINE_STATE = 8'h22;

    localparam int SETUP_LEN       = 8;  // bmRequestType .. wLength
    localparam int LINE_CODING_LEN = 7;  // bytes on the wire

    // line coding record, dte_rate goes out lsb first
    typedef struct packed {
        logic [31:0] dte_rate;     // baud
        logic [7:0]  char_format;  // 0 = 1 stop bit
        logic [7:0]  parity_type;  // 0 = none
        logic [7:0]  data_bits;    // 5,6,7,8 or 16
    } line_coding_t;

    // 115200 8n1, wire order 00 c2 01 00 00 00 08
    localparam line_coding_t LINE_CODING_RESET = '{
        dte_rate:    32'd115200,
        char_format: 8'd0,
        parity_type: 8'd0,
        data_bits:   8'd8
    };

endpackage

/* logic/usb_ep_if.sv */
`timescale 1ns/10ps

// one endpoint's slice of the controller byte interface
interface usb_ep_if;
    import cdc_pkg::*;

    // controller to endpoint, already gated by endpoint number
    logic [7:0] rxdat;   // out data byte
    logic       rxval;   // rxdat valid this cycle
    logic       rxact;   // out packet in progress
    logic       txpop;   // controller took txdat
    logic       txact;   // in packet in progress

    // endpoint to controller
    logic [7:0] txdat;   // next in byte, show-ahead
    logic       txval;   // ep0 data offered
    logic       txcork;  // 1 = nothing to send
    pkt_len_t   txlen;   // bytes in the next in packet

    // top level side, drives the strobes
    modport ctl (
        output rxdat, rxval, rxact, txpop, txact,
        input  txdat, txval, txcork, txlen
    );

    // endpoint logic side
    modport ep (
        input  rxdat, rxval, rxact, txpop, txact,
        output txdat, txval, txcork, txlen
    );

endinterface

/* logic/byte_fifo.sv */
`timescale 1ns/10ps

module byte_fifo #(
    parameter int DEPTH = cdc_pkg::FIFO_DEPTH
) (
    input  logic               PHY_CLKOUT,
    input  logic               RESET_IN,
    input  logic               wr_i,
    input  logic [7:0]         wdat_i,
    input  logic               rd_i,
    output logic [7:0]         rdat_o,   // head, valid while not empty
    output logic               empty_o,
    output logic               full_o,
    output cdc_pkg::fifo_cnt_t cnt_o
);
    import cdc_pkg::*;

    localparam int AW = $clog2(DEPTH);

    logic [7:0]    mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic          do_wr;
    logic          do_rd;

    // wrap at DEPTH, not only at powers of two
    function automatic logic [AW-1:0] ptr_inc(input logic [AW-1:0] p);
        return (p == AW'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign empty_o = (cnt_o == '0);
    assign full_o  = (cnt_o == fifo_cnt_t'(DEPTH));
    assign do_wr   = wr_i & ~full_o;   // drop when full
    assign do_rd   = rd_i & ~empty_o;  // ignore when empty
    assign rdat_o  = mem[rd_ptr];      // show-ahead

    // storage, no reset needed
    always_ff @(posedge PHY_CLKOUT) begin
        if (do_wr) begin
            mem[wr_ptr] <= wdat_i;
        end
    end

    // pointers and occupancy
    always_ff @(posedge PHY_CLKOUT, posedge RESET_IN) begin
        if (RESET_IN) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            cnt_o  <= '0;
        end else begin
            if (do_wr) wr_ptr <= ptr_inc(wr_ptr);
            if (do_rd) rd_ptr <= ptr_inc(rd_ptr);
            case ({do_wr, do_rd})
                2'b10:   cnt_o <= cnt_o + 1'b1;
                2'b01:   cnt_o <= cnt_o - 1'b1;
                default: cnt_o <= cnt_o;  // both or neither
            endcase
        end
    end

endmodule

/* logic/bulk_loopback.sv */
`timescale 1ns/10ps

module bulk_loopback (
    input logic PHY_CLKOUT,
    input logic RESET_IN,
    usb_ep_if.ep ep
);
    import cdc_pkg::*;

    logic [7:0] rx_rdat;
    logic       rx_empty;
    logic       tx_empty;
    logic       tx_full;
    fifo_cnt_t  tx_cnt;
    logic       move;         // rx head -> tx tail this cycle
    pkt_len_t   len_nxt;
    logic       cork_q;
    pkt_len_t   len_q;

    // ==================================================
    // out side, bytes from the host
    // ==================================================
    byte_fifo rx_fifo (
        .PHY_CLKOUT (PHY_CLKOUT),
        .RESET_IN   (RESET_IN),
        .wr_i       (ep.rxval),      // lost if full
        .wdat_i     (ep.rxdat),
        .rd_i       (move),
        .rdat_o     (rx_rdat),
        .empty_o    (rx_empty),
        .full_o     (),              // back-pressure seen on tx side
        .cnt_o      ()
    );

    // one byte per cycle while tx has room
    assign move = ~rx_empty & ~tx_full;

    // ==================================================
    // in side, bytes back to the host
    // ==================================================
    byte_fifo tx_fifo (
        .PHY_CLKOUT (PHY_CLKOUT),
        .RESET_IN   (RESET_IN),
        .wr_i       (move),
        .wdat_i     (rx_rdat),
        .rd_i       (ep.txpop),
        .rdat_o     (ep.txdat),      // head shown before each pop
        .empty_o    (tx_empty),
        .full_o     (tx_full),
        .cnt_o      (tx_cnt)
    );

    // cap packet at MAX_PKT
    assign len_nxt = (tx_cnt > fifo_cnt_t'(MAX_PKT)) ? pkt_len_t'(MAX_PKT)
                                                     : pkt_len_t'(tx_cnt);

    // ==================================================
    // cork and packet length, registered
    // ==================================================
    always_ff @(posedge PHY_CLKOUT, posedge RESET_IN) begin
        if (RESET_IN) begin
            cork_q <= 1'b1;           // corked until data arrives
            len_q  <= '0;
        end else begin
            cork_q <= tx_empty;
            if (!ep.txact) begin
                len_q <= len_nxt;     // frozen during a packet
            end
        end
    end

    assign ep.txcork = cork_q;
    assign ep.txlen  = len_q;
    assign ep.txval  = 1'b0;          // bulk goes by cork only

endmodule

/* logic/line_coding_ctrl.sv */
`timescale 1ns/10ps

module line_coding_ctrl (
    input  logic       PHY_CLKOUT,
    input  logic       RESET_IN,
    input  logic       setup_i,       // setup stage on ep0
    usb_ep_if.ep       ep,
    output logic [1:0] line_state_o   // [0] dtr, [1] rts
);
    import cdc_pkg::*;

    logic [2:0]   setup_cnt;    // byte index inside the setup packet
    logic [7:0]   req_code;     // bRequest
    logic         send_act;     // GET reply in flight
    logic         coll_act;     // SET data expected
    logic [2:0]   byte_idx;     // record byte for either direction
    line_coding_t lc;
    logic         setup_byte;
    logic         last_setup;
    logic         data_byte;
    logic         pop;

    // record byte k in wire order
    function automatic logic [7:0] wire_byte(input line_coding_t r, input logic [2:0] k);
        case (k)
            3'd0:    return r.dte_rate[7:0];
            3'd1:    return r.dte_rate[15:8];
            3'd2:    return r.dte_rate[23:16];
            3'd3:    return r.dte_rate[31:24];
            3'd4:    return r.char_format;
            3'd5:    return r.parity_type;
            default: return r.data_bits;
        endcase
    endfunction

    assign setup_byte = setup_i & ep.rxval;
    assign last_setup = setup_byte & (setup_cnt == 3'(SETUP_LEN - 1));
    assign data_byte  = ~setup_i & ep.rxact & ep.rxval & coll_act;
    assign pop        = ep.txact & ep.txpop & send_act;

    // ==================================================
    // setup parser and request engine
    // ==================================================
    always_ff @(posedge PHY_CLKOUT, posedge RESET_IN) begin
        if (RESET_IN) begin
            setup_cnt    <= '0;
            req_code     <= '0;
            send_act     <= 1'b0;
            coll_act     <= 1'b0;
            byte_idx     <= '0;
            line_state_o <= '0;
            lc           <= LINE_CODING_RESET;
        end else if (setup_i) begin
            if (setup_byte) begin
                setup_cnt <= setup_cnt + 1'b1;  // wraps after byte 7
                case (setup_cnt)
                    3'd0: begin
                        send_act <= 1'b0;        // new request aborts old one
                        coll_act <= 1'b0;
                    end
                    3'd1: req_code <= ep.rxdat;
                    3'd2: begin
                        if (req_code == REQ_SET_CTRL_LINE_STATE)
                            line_state_o <= ep.rxdat[1:0];  // wValue low bits
                    end
                    default: ;
                endcase
            end
            if (last_setup) begin
                byte_idx <= '0;
                send_act <= (req_code == REQ_GET_LINE_CODING);
                coll_act <= (req_code == REQ_SET_LINE_CODING);
            end
        end else begin
            setup_cnt <= '0;
            if (data_byte) begin                 // SET data stage
                case (byte_idx)
                    3'd0:    lc.dte_rate[7:0]   <= ep.rxdat;
                    3'd1:    lc.dte_rate[15:8]  <= ep.rxdat;
                    3'd2:    lc.dte_rate[23:16] <= ep.rxdat;
                    3'd3:    lc.dte_rate[31:24] <= ep.rxdat;
                    3'd4:    lc.char_format     <= ep.rxdat;
                    3'd5:    lc.parity_type     <= ep.rxdat;
                    default: lc.data_bits       <= ep.rxdat;
                endcase
                byte_idx <= byte_idx + 1'b1;
                if (byte_idx == 3'(LINE_CODING_LEN - 1)) coll_act <= 1'b0;
            end
            if (pop) begin                       // GET data stage
                byte_idx <= byte_idx + 1'b1;
                if (byte_idx == 3'(LINE_CODING_LEN - 1)) send_act <= 1'b0;
            end
        end
    end

    assign ep.txdat  = wire_byte(lc, byte_idx);  // show-ahead
    assign ep.txval  = send_act;
    assign ep.txcork = ~send_act;
    assign ep.txlen  = pkt_len_t'(LINE_CODING_LEN);

endmodule

/* logic/cdc_app_top.sv */
`timescale 1ns/10ps

module cdc_app_top (
    input  logic              PHY_CLKOUT,
    input  logic              RESET_IN,
    input  cdc_pkg::endpt_t   endpt_i,
    input  logic              setup_i,
    input  logic [7:0]        rxdat_i,
    input  logic              rxval_i,
    input  logic              rxact_i,
    input  logic              txpop_i,
    input  logic              txact_i,
    output logic [7:0]        txdat_o,
    output logic              txval_o,
    output logic              txcork_o,
    output cdc_pkg::pkt_len_t txdat_len_o,
    output logic [1:0]        line_state_o
);
    import cdc_pkg::*;

    logic sel_ctrl;
    logic sel_bulk;

    usb_ep_if ctrl_ep ();
    usb_ep_if bulk_ep ();

    // ==================================================
    // endpoint decode, done once here
    // ==================================================
    assign sel_ctrl = (endpt_i == EP_CTRL);
    assign sel_bulk = (endpt_i == EP_BULK);

    assign ctrl_ep.rxdat = rxdat_i;               // data ungated, strobes gated
    assign ctrl_ep.rxval = rxval_i & sel_ctrl;
    assign ctrl_ep.rxact = rxact_i & sel_ctrl;
    assign ctrl_ep.txpop = txpop_i & sel_ctrl;
    assign ctrl_ep.txact = txact_i & sel_ctrl;

    assign bulk_ep.rxdat = rxdat_i;
    assign bulk_ep.rxval = rxval_i & sel_bulk;
    assign bulk_ep.rxact = rxact_i & sel_bulk;
    assign bulk_ep.txpop = txpop_i & sel_bulk;
    assign bulk_ep.txact = txact_i & sel_bulk;

    line_coding_ctrl u_ctrl (
        .PHY_CLKOUT   (PHY_CLKOUT),
        .RESET_IN     (RESET_IN),
        .setup_i      (setup_i & sel_ctrl),  // setup only ever on ep0
        .ep           (ctrl_ep.ep),
        .line_state_o (line_state_o)
    );

    bulk_loopback u_bulk (
        .PHY_CLKOUT (PHY_CLKOUT),
        .RESET_IN   (RESET_IN),
        .ep         (bulk_ep.ep)
    );

    // tx mux, unknown endpoints stay corked
    always_comb begin
        txdat_o     = 8'h00;
        txval_o     = 1'b0;
        txcork_o    = 1'b1;
        txdat_len_o = '0;
        if (sel_ctrl) begin
            txdat_o     = ctrl_ep.txdat;
            txval_o     = ctrl_ep.txval;
            txcork_o    = ctrl_ep.txcork;
            txdat_len_o = ctrl_ep.txlen;
        end else if (sel_bulk) begin
            txdat_o     = bulk_ep.txdat;
            txval_o     = bulk_ep.txval;     // always 0 for bulk
            txcork_o    = bulk_ep.txcork;
            txdat_len_o = bulk_ep.txlen;
        end
    end

endmodule

/* tb/cdc_app_properties.sv */
`timescale 1ns/10ps

module cdc_app_properties (
    input logic              PHY_CLKOUT,
    input logic              RESET_IN,
    input cdc_pkg::endpt_t   endpt_i,
    input logic              txval_i,
    input logic              txcork_i,
    input cdc_pkg::pkt_len_t txdat_len_i
);
    import cdc_pkg::*;

    // ==================================================
    // top level port rules
    // ==================================================
    a_txval_ep0 : assert property (
        @(posedge PHY_CLKOUT) disable iff (RESET_IN)
        txval_i |-> (endpt_i == EP_CTRL)               // only ep0 offers by txval
    ) else $error("txval_o high on endpoint %0d", endpt_i);

    a_bulk_len_cap : assert property (
        @(posedge PHY_CLKOUT)
        (endpt_i == EP_BULK) |-> (txdat_len_i <= pkt_len_t'(MAX_PKT))
    ) else $error("bulk packet length %0d above max", txdat_len_i);

    a_cork_in_reset : assert property (
        @(posedge PHY_CLKOUT)
        RESET_IN |-> txcork_i                          // nothing offered in reset
    ) else $error("txcork_o low during reset");

endmodule

bind cdc_app_top cdc_app_properties u_props (
    .PHY_CLKOUT  (PHY_CLKOUT),
    .RESET_IN    (RESET_IN),
    .endpt_i     (endpt_i),
    .txval_i     (txval_o),
    .txcork_i    (txcork_o),
    .txdat_len_i (txdat_len_o)
);

/* tb/tb_cdc_app.sv */
`timescale 1ns/10ps

module tb_cdc_app;
    import cdc_pkg::*;

    logic       PHY_CLKOUT;
    logic       RESET_IN;
    endpt_t     endpt;
    logic       setup;
    logic [7:0] rxdat;
    logic       rxval;
    logic       rxact;
    logic       txpop;
    logic       txact;
    logic [7:0] txdat;
    logic       txval;
    logic       txcork;
    pkt_len_t   txdat_len;
    logic [1:0] line_state;

    logic [7:0] out_q[$];    // next OUT or setup transfer
    logic [7:0] in_q[$];     // collected from IN packets
    logic [7:0] exp_q[$];    // expected IN bytes
    int         checks;
    int         errors;
    int         test_errs;   // errors inside the current test

    cdc_app_top dut0 (
        .PHY_CLKOUT   (PHY_CLKOUT),
        .RESET_IN     (RESET_IN),
        .endpt_i      (endpt),
        .setup_i      (setup),
        .rxdat_i      (rxdat),
        .rxval_i      (rxval),
        .rxact_i      (rxact),
        .txpop_i      (txpop),
        .txact_i      (txact),
        .txdat_o      (txdat),
        .txval_o      (txval),
        .txcork_o     (txcork),
        .txdat_len_o  (txdat_len),
        .line_state_o (line_state)
    );

    always #5 PHY_CLKOUT = ~PHY_CLKOUT;  // 100 MHz

    // ==================================================
    // checking
    // ==================================================
    task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string msg);
        checks++;
        if (got !== exp) begin
            errors++;
            test_errs++;
            $display("MISMATCH at %0t: %s, got %0h expected %0h", $time, msg, got, exp);
        end
    endtask

    task automatic compare_bytes(input string msg);
        check_eq(32'(in_q.size()), 32'(exp_q.size()), {msg, " byte count"});
        foreach (exp_q[i]) begin
            if (i < in_q.size())
                check_eq(32'(in_q[i]), 32'(exp_q[i]), $sformatf("%s byte %0d", msg, i));
        end
        in_q.delete();
        exp_q.delete();
    endtask

    task automatic report_test(input string name);
        if (test_errs == 0) begin
            $display("test %-20s ok", name);
        end else begin
            $display("test %-20s %0d errors", name, test_errs);
        end
        test_errs = 0;
    endtask

    // ==================================================
    // controller model
    // ==================================================
    task automatic send_out_bytes(input endpt_t ep, input logic is_setup);
        foreach (out_q[i]) begin
            @(posedge PHY_CLKOUT);
            endpt <= ep;
            setup <= is_setup;
            rxact <= 1'b1;
            rxval <= 1'b1;
            rxdat <= out_q[i];
        end
        @(posedge PHY_CLKOUT);
        setup <= 1'b0;
        rxact <= 1'b0;
        rxval <= 1'b0;
        out_q.delete();
    endtask

    task automatic send_setup(input logic [7:0] req_type, input logic [7:0] req,
                              input logic [15:0] wvalue, input logic [15:0] wlength);
        logic [63:0] pkt;
        pkt = {wlength, 16'h0000, wvalue, req, req_type};  // wIndex 0
        for (int k = 0; k < SETUP_LEN; k++) out_q.push_back(pkt[8*k +: 8]);
        send_out_bytes(EP_CTRL, 1'b1);
    endtask

    task automatic wait_cork(input logic level);
        bit seen;
        seen = 1'b0;
        for (int n = 0; n < 200; n++) begin
            @(negedge PHY_CLKOUT);
            if (txcork === level) begin
                seen = 1'b1;
                break;
            end
        end
        if (!seen) begin
            errors++;
            test_errs++;
            $display("timeout at %0t: cork never went to %0d", $time, level);
        end
    endtask

    // last OUT byte needs two cycles to reach tx, one more for the length
    task automatic wait_uncorked();
        repeat (2) @(posedge PHY_CLKOUT);
        wait_cork(1'b0);
    endtask

    // pops every cycle, head sampled mid-cycle before each pop edge
    task automatic read_in_packet(input endpt_t ep, input int len);
        @(posedge PHY_CLKOUT);
        endpt <= ep;
        txact <= 1'b1;
        txpop <= 1'b1;
        for (int i = 0; i < len; i++) begin
            @(negedge PHY_CLKOUT);
            in_q.push_back(txdat);
        end
        @(posedge PHY_CLKOUT);
        txpop <= 1'b0;
        txact <= 1'b0;
    endtask

    task automatic fill_random(input int n);
        logic [7:0] b;
        for (int i = 0; i < n; i++) begin
            b = 8'($urandom);
            out_q.push_back(b);
            exp_q.push_back(b);
        end
    endtask

    // ==================================================
    // directed tests
    // ==================================================
    task automatic check_reset_state();
        for (int k = 0; k < 2; k++) begin
            @(posedge PHY_CLKOUT);
            endpt <= (k == 0) ? EP_BULK : EP_CTRL;
            @(negedge PHY_CLKOUT);
            check_eq(32'(txcork), 32'd1, $sformatf("cork after reset, pass %0d", k));
            check_eq(32'(txval), 32'd0, $sformatf("txval after reset, pass %0d", k));
            check_eq(32'(line_state), 32'd0, $sformatf("line state after reset, pass %0d", k));
        end
    endtask

    task automatic loop_short_packet();
        fill_random(20);
        send_out_bytes(EP_BULK, 1'b0);
        wait_uncorked();
        check_eq(32'(txdat_len), 32'd20, "short packet length");
        read_in_packet(EP_BULK, 20);
        compare_bytes("short loopback");
        wait_cork(1'b1);
    endtask

    task automatic loop_long_transfer();
        fill_random(100);
        send_out_bytes(EP_BULK, 1'b0);
        wait_uncorked();
        check_eq(32'(txdat_len), 32'd64, "first packet length");  // capped
        read_in_packet(EP_BULK, 64);
        wait_uncorked();
        check_eq(32'(txdat_len), 32'd36, "second packet length");
        read_in_packet(EP_BULK, 36);
        compare_bytes("long loopback");
        wait_cork(1'b1);
    endtask

    task automatic get_default_coding();
        // 115200 8n1 in wire order
        logic [7:0] dflt [7] = '{8'h00, 8'hC2, 8'h01, 8'h00, 8'h00, 8'h00, 8'h08};
        foreach (dflt[i]) begin
            exp_q.push_back(dflt[i]);
        end
        send_setup(8'hA1, REQ_GET_LINE_CODING, 16'h0000, 16'd7);
        wait_uncorked();
        check_eq(32'(txdat_len), 32'd7, "GET reply length");
        read_in_packet(EP_CTRL, 7);
        @(negedge PHY_CLKOUT);
        check_eq(32'(txval), 32'd0, "txval after GET reply");
        compare_bytes("default line coding");
    endtask

    task automatic set_then_get_coding();
        send_setup(8'h21, REQ_SET_LINE_CODING, 16'h0000, 16'd7);
        fill_random(7);
        send_out_bytes(EP_CTRL, 1'b0);     // data stage
        send_setup(8'hA1, REQ_GET_LINE_CODING, 16'h0000, 16'd7);
        wait_uncorked();
        read_in_packet(EP_CTRL, 7);
        compare_bytes("line coding readback");
    endtask

    task automatic toggle_line_state();
        send_setup(8'h21, REQ_SET_CTRL_LINE_STATE, 16'h0003, 16'd0);
        @(negedge PHY_CLKOUT);
        check_eq(32'(line_state), 32'd3, "line state, dtr and rts");
        send_setup(8'h21, REQ_SET_CTRL_LINE_STATE, 16'h0001, 16'd0);
        @(negedge PHY_CLKOUT);
        check_eq(32'(line_state), 32'd1, "line state, dtr only");
    endtask

    initial begin
        void'($urandom(32'h2d6f));
        PHY_CLKOUT = 1'b0;
        RESET_IN   = 1'b1;
        endpt      = EP_BULK;
        setup      = 1'b0;
        rxdat      = 8'h00;
        rxval      = 1'b0;
        rxact      = 1'b0;
        txpop      = 1'b0;
        txact      = 1'b0;
        checks     = 0;
        errors     = 0;
        test_errs  = 0;
        repeat (5) @(posedge PHY_CLKOUT);
        RESET_IN <= 1'b0;

        check_reset_state();
        report_test("reset state");
        loop_short_packet();
        report_test("short loopback");
        loop_long_transfer();
        report_test("long loopback");
        get_default_coding();
        report_test("default coding");
        set_then_get_coding();
        report_test("set then get");
        toggle_line_state();
        report_test("line state");

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

/* sim.f */
logic/cdc_pkg.sv
logic/usb_ep_if.sv
logic/byte_fifo.sv
logic/bulk_loopback.sv
logic/line_coding_ctrl.sv
logic/cdc_app_top.sv
tb/cdc_app_properties.sv
tb/tb_cdc_app.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the cdc application testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_cdc_app -Mdir obj_dir -o tb_cdc_app -f sim.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_cdc_app > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Regression passed$" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1
